//--- rtl/cache_ctrl_fsm.sv
//--------------------------------------------------------------------------
// blocking access FSM, one request in flight
// loads are granted on acceptance, stores when written or sent out
// SRAM grant is only checked on acceptance and in the store write
// miss and bypass grants never both come for one request
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module cache_ctrl_fsm
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  ctrl_dp_if.fsm    dp,
  // core side
  input  logic      data_req_i,
  input  logic      data_we_i,
  input  logic      tag_valid_i,
  input  logic      stall_i,
  input  logic      bypass_i,
  // responses
  input  logic      sram_gnt_i,
  input  way_mask_t hit_way_i,
  input  logic      miss_gnt_i,
  input  logic      bypass_gnt_i,
  input  logic      critical_word_valid_i,
  input  logic      bypass_valid_i,
  // status and strobes
  output logic      busy_o,
  output logic      data_gnt_o,
  output logic      data_rvalid_o,
  output way_mask_t sram_req_o,
  output logic      sram_we_o,
  output rsel_t     rsel_o,
  output logic      miss_valid_o
);

  ctrl_state_e state_d, state_q;
  way_mask_t   hit_ways_d, hit_ways_q;
  logic        tag_ready;
  logic        uncacheable;

  assign busy_o            = (state_q != IDLE);
  // nonzero only while a store hit waits for its write
  assign dp.store_hit_ways = hit_ways_q;

  // stores go on without tag_valid_i, the tag is there one cycle later
  assign tag_ready   = tag_valid_i | dp.req_we;
  assign uncacheable = (dp.cur_tag >= cacheable_tag_limit);

  //--------------------------------------------------------------------------
  // next state and strobes
  //--------------------------------------------------------------------------
  always_comb begin : next_state
    state_d          = state_q;
    hit_ways_d       = '0;
    data_gnt_o       = 1'b0;
    data_rvalid_o    = 1'b0;
    sram_req_o       = '0;
    sram_we_o        = 1'b0;
    rsel_o           = rsel_line;
    miss_valid_o     = 1'b0;
    dp.capture       = 1'b0;
    dp.save_tag      = 1'b0;
    dp.force_bypass  = 1'b0;

    case (state_q)
      IDLE: begin
        if (data_req_i && !stall_i) begin
          if (bypass_i) begin
            // uncached, no SRAM lookup needed
            dp.capture      = 1'b1;
            dp.force_bypass = 1'b1;
            data_gnt_o      = !data_we_i;
            state_d         = WAIT_TAG_BYPASSED;
          end else begin
            // read all ways of the set
            sram_req_o = '1;
            if (sram_gnt_i) begin
              dp.capture = 1'b1;
              data_gnt_o = !data_we_i;
              state_d    = WAIT_TAG;
            end
          end
        end
      end

      WAIT_TAG: begin
        if (tag_ready) begin
          dp.save_tag = 1'b1;
          if (uncacheable) begin
            // outside the cacheable region, send it around the cache
            dp.force_bypass = 1'b1;
            state_d         = WAIT_REFILL_GNT;
          end else if (dp.any_hit) begin
            if (!dp.req_we) begin
              // load hit, word goes out this cycle
              data_rvalid_o = 1'b1;
              state_d       = IDLE;
            end else begin
              // store hit needs a second access to write
              hit_ways_d = hit_way_i;
              state_d    = STORE_REQ;
            end
          end else begin
            state_d = WAIT_REFILL_GNT;
          end
        end else begin
          // tag still pending, keep the set read alive
          sram_req_o = '1;
        end
      end

      WAIT_TAG_BYPASSED: begin
        if (tag_ready) begin
          dp.save_tag     = 1'b1;
          dp.force_bypass = 1'b1;
          state_d         = WAIT_REFILL_GNT;
        end
      end

      STORE_REQ: begin
        // word, byte enables and dirty marks into the hit way
        sram_req_o = hit_ways_q;
        sram_we_o  = 1'b1;
        if (sram_gnt_i) begin
          data_gnt_o = 1'b1;
          state_d    = IDLE;
        end else begin
          hit_ways_d = hit_ways_q;
        end
      end

      WAIT_REFILL_GNT: begin
        miss_valid_o = 1'b1;
        if (bypass_gnt_i) begin
          if (dp.req_we) begin
            // uncached store is done once it is taken
            data_gnt_o = 1'b1;
            state_d    = IDLE;
          end else begin
            state_d = WAIT_REFILL_VALID;
          end
        end
        if (miss_gnt_i) begin
          if (dp.req_we) begin
            data_gnt_o = 1'b1;
            state_d    = IDLE;
          end else begin
            state_d = WAIT_CRITICAL_WORD;
          end
        end
      end

      WAIT_CRITICAL_WORD: begin
        rsel_o = rsel_critical;
        if (critical_word_valid_i) begin
          data_rvalid_o = 1'b1;
          state_d       = IDLE;
        end
      end

      WAIT_REFILL_VALID: begin
        rsel_o = rsel_bypass;
        if (bypass_valid_i) begin
          data_rvalid_o = 1'b1;
          state_d       = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  //--------------------------------------------------------------------------
  // state registers
  //--------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      hit_ways_q <= '0;
    end else begin
      state_q    <= state_d;
      hit_ways_q <= hit_ways_d;
    end
  end

endmodule

//--- rtl/cache_ctrl_pkg.sv
//--------------------------------------------------------------------------
// controller states and read data source select
// one request in flight, every request ends back in IDLE
//--------------------------------------------------------------------------
package cache_ctrl_pkg;

  // access sequencing states
  typedef enum logic [2:0] {
    IDLE,
    // cached access, SRAM read issued, waiting for the tag
    WAIT_TAG,
    // uncached access, waiting for the tag
    WAIT_TAG_BYPASSED,
    // second SRAM access of a store hit
    STORE_REQ,
    // miss or bypass request offered to the miss unit
    WAIT_REFILL_GNT,
    // load miss, waiting for the refill word
    WAIT_CRITICAL_WORD,
    // uncached load, waiting for the bypass answer
    WAIT_REFILL_VALID
  } ctrl_state_e;

  // source of data_rdata_o
  typedef logic [1:0] rsel_t;

  localparam rsel_t rsel_line     = 2'd0;
  localparam rsel_t rsel_critical = 2'd1;
  localparam rsel_t rsel_bypass   = 2'd2;

endpackage

//--- rtl/cache_ctrl_top.sv
//--------------------------------------------------------------------------
// data cache controller for one core load/store port
// single-ported SRAM answers one cycle after sram_req_o
// critical and bypass words are single 32-bit words
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module cache_ctrl_top
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             bypass_i,
  input  logic             stall_i,
  output logic             busy_o,
  // core port
  input  logic             data_req_i,
  input  logic             data_we_i,
  input  be_t              data_be_i,
  input  word_t            data_wdata_i,
  input  index_t           address_index_i,
  input  tag_t             address_tag_i,
  input  logic             tag_valid_i,
  output logic             data_gnt_o,
  output logic             data_rvalid_o,
  output word_t            data_rdata_o,
  // SRAM port
  output way_mask_t        sram_req_o,
  output index_t           sram_addr_o,
  output logic             sram_we_o,
  output line_t            sram_data_o,
  output line_be_t         sram_be_o,
  output tag_t             sram_tag_o,
  input  logic             sram_gnt_i,
  input  line_t [ways-1:0] sram_rdata_i,
  input  way_mask_t        hit_way_i,
  // miss port
  output logic             miss_valid_o,
  output logic             miss_bypass_o,
  output paddr_t           miss_addr_o,
  output logic             miss_we_o,
  output be_t              miss_be_o,
  output word_t            miss_wdata_o,
  input  logic             miss_gnt_i,
  input  word_t            critical_word_i,
  input  logic             critical_word_valid_i,
  // bypass port
  input  logic             bypass_gnt_i,
  input  logic             bypass_valid_i,
  input  word_t            bypass_data_i
);

  rsel_t rsel;

  ctrl_dp_if i_dp_if ();

  cache_ctrl_fsm i_cache_ctrl_fsm (
    .clk_i, .rst_ni, .dp(i_dp_if.fsm),
    .data_req_i, .data_we_i, .tag_valid_i, .stall_i, .bypass_i,
    .sram_gnt_i, .hit_way_i, .miss_gnt_i, .bypass_gnt_i,
    .critical_word_valid_i, .bypass_valid_i,
    .busy_o, .data_gnt_o, .data_rvalid_o, .sram_req_o, .sram_we_o,
    .rsel_o(rsel), .miss_valid_o
  );

  req_buffer i_req_buffer (
    .clk_i, .rst_ni, .dp(i_dp_if.rbuf),
    .address_index_i, .address_tag_i, .data_be_i, .data_wdata_i, .data_we_i
  );

  // SRAM takes the live index only while no request is held
  line_datapath i_line_datapath (
    .dp(i_dp_if.dp), .rsel_i(rsel),
    .sram_rdata_i, .hit_way_i, .critical_word_i, .bypass_data_i,
    .address_index_i, .capture_idle_i(~busy_o),
    .data_rdata_o, .sram_addr_o, .sram_tag_o, .sram_data_o, .sram_be_o,
    .miss_addr_o, .miss_bypass_o, .miss_we_o, .miss_be_o, .miss_wdata_o
  );

endmodule

//--- rtl/cache_geom_pkg.sv
//--------------------------------------------------------------------------
// data cache geometry: 4 ways, 128-bit lines, 32-bit words, 32-bit paddr
// index includes the byte offset, a paddr is the tag followed by the index
// tags at or above cacheable_tag_limit are always served uncached
//--------------------------------------------------------------------------
package cache_geom_pkg;

  // word and line sizes
  localparam int unsigned xlen           = 32;
  localparam int unsigned word_bytes     = xlen / 8;
  localparam int unsigned ways           = 4;
  localparam int unsigned line_width     = 128;
  localparam int unsigned line_bytes     = line_width / 8;

  // address split
  localparam int unsigned offset_width   = $clog2(line_bytes);
  localparam int unsigned index_width    = 12;
  localparam int unsigned tag_width      = 20;
  localparam int unsigned word_sel_width = $clog2(line_width / xlen);
  // byte number inside a word, below the word number
  localparam int unsigned byte_sel_width = offset_width - word_sel_width;

  typedef logic [xlen-1:0]                  word_t;
  typedef logic [word_bytes-1:0]            be_t;
  typedef logic [index_width-1:0]           index_t;
  typedef logic [tag_width-1:0]             tag_t;
  typedef logic [ways-1:0]                  way_mask_t;
  typedef logic [line_width-1:0]            line_t;
  typedef logic [line_bytes-1:0]            line_be_t;
  typedef logic [tag_width+index_width-1:0] paddr_t;

  // upper half of the tag space is device memory
  localparam tag_t cacheable_tag_limit = 20'h80000;

endpackage

//--- rtl/ctrl_dp_if.sv
//--------------------------------------------------------------------------
// link between the access FSM, the request buffer and the line datapath
// req_* fields are only meaningful after the capture strobe
//--------------------------------------------------------------------------
`timescale 1ns/100ps

interface ctrl_dp_if
  import cache_geom_pkg::*;
();

  // strobes from the FSM
  logic      capture;
  logic      save_tag;
  logic      force_bypass;
  way_mask_t store_hit_ways;

  // buffered request
  index_t    req_index;
  tag_t      req_tag;
  be_t       req_be;
  word_t     req_wdata;
  logic      req_we;
  logic      req_bypass;
  // live tag, incoming in the save cycle
  tag_t      cur_tag;

  // lookup result
  logic      any_hit;

  modport fsm (
    output capture, save_tag, force_bypass, store_hit_ways,
    input  req_we, cur_tag, any_hit
  );

  modport rbuf (
    input  capture, save_tag, force_bypass,
    output req_index, req_tag, req_be, req_wdata, req_we, req_bypass, cur_tag
  );

  modport dp (
    input  store_hit_ways, req_index, req_tag, req_be, req_wdata, req_we, req_bypass,
    input  cur_tag,
    output any_hit
  );

endinterface

//--- rtl/line_datapath.sv
//--------------------------------------------------------------------------
// hit way select, word extract and store line build
// hit_way_i is expected one-hot on a hit, several ways are ORed
// a store write sets valid on the addressed way and dirty where sram_be_o is set
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module line_datapath
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
(
  ctrl_dp_if.dp            dp,
  input  rsel_t            rsel_i,
  input  line_t [ways-1:0] sram_rdata_i,
  input  way_mask_t        hit_way_i,
  input  word_t            critical_word_i,
  input  word_t            bypass_data_i,
  input  index_t           address_index_i,
  input  logic             capture_idle_i,
  // core read data
  output word_t            data_rdata_o,
  // SRAM side
  output index_t           sram_addr_o,
  output tag_t             sram_tag_o,
  output line_t            sram_data_o,
  output line_be_t         sram_be_o,
  // miss unit side
  output paddr_t           miss_addr_o,
  output logic             miss_bypass_o,
  output logic             miss_we_o,
  output be_t              miss_be_o,
  output word_t            miss_wdata_o
);

  logic [word_sel_width-1:0] word_sel;
  line_t                     hit_line;
  word_t                     line_word;

  // word number within the line, from the buffered index
  assign word_sel   = dp.req_index[offset_width-1:byte_sel_width];
  assign dp.any_hit = |hit_way_i;

  always_comb begin : way_select
    hit_line = '0;
    for (int unsigned w = 0; w < ways; w++) begin
      if (hit_way_i[w]) begin
        hit_line = hit_line | sram_rdata_i[w];
      end
    end
  end

  assign line_word = hit_line[word_sel*xlen +: xlen];

  always_comb begin : read_mux
    case (rsel_i)
      rsel_line:     data_rdata_o = line_word;
      rsel_critical: data_rdata_o = critical_word_i;
      rsel_bypass:   data_rdata_o = bypass_data_i;
      default:       data_rdata_o = '0;
    endcase
  end

  //--------------------------------------------------------------------------
  // store line, only driven while a hit way is latched
  //--------------------------------------------------------------------------
  always_comb begin : store_line
    sram_data_o = '0;
    sram_be_o   = '0;
    if (|dp.store_hit_ways) begin
      sram_data_o[word_sel*xlen +: xlen]             = dp.req_wdata;
      sram_be_o[word_sel*word_bytes +: word_bytes]   = dp.req_be;
    end
  end

  // live index in IDLE, buffered index for repeats and the write
  assign sram_addr_o = capture_idle_i ? address_index_i : dp.req_index;
  // tag compare happens one cycle after the read
  assign sram_tag_o  = dp.cur_tag;

  // miss request fields
  assign miss_addr_o   = {dp.req_tag, dp.req_index};
  assign miss_bypass_o = dp.req_bypass;
  assign miss_we_o     = dp.req_we;
  assign miss_be_o     = dp.req_be;
  assign miss_wdata_o  = dp.req_wdata;

endmodule

//--- rtl/req_buffer.sv
//--------------------------------------------------------------------------
// holds the accepted request, the tag arrives later on save_tag
// cur_tag passes the incoming tag through in the save cycle
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module req_buffer
  import cache_geom_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  ctrl_dp_if.rbuf dp,
  input  index_t address_index_i,
  input  tag_t   address_tag_i,
  input  be_t    data_be_i,
  input  word_t  data_wdata_i,
  input  logic   data_we_i
);

  index_t index_q;
  tag_t   tag_q;
  be_t    be_q;
  word_t  wdata_q;
  logic   we_q;
  logic   bypass_q;

  // request kind
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q     <= 1'b0;
      bypass_q <= 1'b0;
    end else if (dp.capture) begin
      we_q     <= data_we_i;
      bypass_q <= dp.force_bypass;
    end else if (dp.save_tag && dp.force_bypass) begin
      // tag found outside the cacheable region
      bypass_q <= 1'b1;
    end
  end

  // address and write payload
  always_ff @(posedge clk_i) begin
    if (dp.capture) begin
      index_q <= address_index_i;
      be_q    <= data_be_i;
      wdata_q <= data_wdata_i;
    end
    if (dp.save_tag) begin
      tag_q <= address_tag_i;
    end
  end

  assign dp.req_index  = index_q;
  assign dp.req_tag    = tag_q;
  assign dp.req_be     = be_q;
  assign dp.req_wdata  = wdata_q;
  assign dp.req_we     = we_q;
  assign dp.req_bypass = bypass_q;
  assign dp.cur_tag    = dp.save_tag ? address_tag_i : tag_q;

endmodule

//--- run.sh
#!/bin/sh
# build and run the cache controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cache_ctrl -f sources.f

out="$(./obj_dir/Vtb_cache_ctrl 2>&1 || true)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Test OK'; then
  exit 0
else
  exit 1
fi

//--- sim/cache_ctrl_properties.sv
//----------------------------------------------------------------------------
// protocol assertions, bound into every cache_ctrl_top instance
// reads only top-level ports, IDLE is seen as busy_o low
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module cache_ctrl_properties
  import cache_geom_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      busy_o,
  input logic      data_gnt_o,
  input logic      data_rvalid_o,
  input way_mask_t sram_req_o,
  input logic      sram_we_o,
  input logic      miss_valid_o,
  input logic      miss_gnt_i,
  input logic      bypass_gnt_i
);

  // all strobes quiet while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !busy_o && !data_gnt_o && !data_rvalid_o && (sram_req_o == '0)
                && !sram_we_o && !miss_valid_o)
    else $error("strobe active during reset");

  // idle only issues lookups and load grants
  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_o |-> !data_rvalid_o && !sram_we_o && !miss_valid_o)
    else $error("response strobe active in idle");

  // miss request is held until the miss or bypass unit takes it
  miss_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_valid_o && !miss_gnt_i && !bypass_gnt_i |=> miss_valid_o)
    else $error("miss request dropped without a grant");

  // read data never overlaps an open miss request
  no_rvalid_in_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(data_rvalid_o && miss_valid_o))
    else $error("read data returned with a miss request open");

endmodule

bind cache_ctrl_top cache_ctrl_properties i_cache_ctrl_properties (
  .clk_i, .rst_ni, .busy_o, .data_gnt_o, .data_rvalid_o, .sram_req_o,
  .sram_we_o, .miss_valid_o, .miss_gnt_i, .bypass_gnt_i
);

//--- sim/tb_cache_ctrl.sv
//----------------------------------------------------------------------------
// testbench for cache_ctrl_top with SRAM, miss and bypass unit models
// every set holds tags 0x00100..0x00103 in ways 0..3 after reset
// the backing memory ignores writes, so stored words are not read back uncached
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_cache_ctrl;
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;

  localparam int num_requests = 30;
  localparam tag_t first_tag  = 20'h00100;

  logic clk_i, rst_ni, bypass_i, stall_i, busy_o;
  logic data_req_i, data_we_i, tag_valid_i, data_gnt_o, data_rvalid_o;
  be_t data_be_i;
  word_t data_wdata_i, data_rdata_o;
  index_t address_index_i, sram_addr_o;
  tag_t address_tag_i, sram_tag_o;
  way_mask_t sram_req_o, hit_way_i;
  logic sram_we_o, sram_gnt_i;
  line_t sram_data_o;
  line_be_t sram_be_o;
  line_t [ways-1:0] sram_rdata_i;
  logic miss_valid_o, miss_bypass_o, miss_we_o, miss_gnt_i, critical_word_valid_i;
  paddr_t miss_addr_o;
  be_t miss_be_o;
  word_t miss_wdata_o, critical_word_i;
  logic bypass_gnt_i, bypass_valid_i;
  word_t bypass_data_i;

  // SRAM model state
  tag_t tag_mem [ways][256];
  logic valid_mem [ways][256];
  logic [3:0] dirty_mem [ways][256];
  line_t line_mem [ways][256];
  logic [7:0] rd_set_q;
  logic rd_valid_q;

  // expected miss request and expected cache contents after store hits
  paddr_t exp_miss_addr;
  logic exp_bypass;
  logic exp_we;
  be_t exp_be;
  word_t exp_wdata;
  word_t shadow [paddr_t];

  cache_ctrl_top i_cache_ctrl_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic word_t backing_word(paddr_t a);
    return {a[31:2], 2'b00} ^ 32'h5A3C_96E1;
  endfunction

  // preload pattern, different from the backing memory
  function automatic word_t fill_word(paddr_t a);
    return {a[31:2], 2'b00} ^ 32'hA5C3_0F1E;
  endfunction

  function automatic word_t cached_word(paddr_t a);
    if (shadow.exists(a)) return shadow[a];
    return fill_word(a);
  endfunction

  function automatic word_t merge_word(word_t old, word_t wdata, be_t be);
    word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic report_mismatch(string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  //--------------------------------------------------------------------------
  // SRAM model, reads answer one cycle later, writes need the grant
  //--------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
      rd_set_q   <= '0;
      for (int w = 0; w < ways; w++) begin
        for (int s = 0; s < 256; s++) begin
          tag_mem[w][s]   <= first_tag + tag_t'(w);
          valid_mem[w][s] <= 1'b1;
          dirty_mem[w][s] <= '0;
          for (int l = 0; l < 4; l++) begin
            line_mem[w][s][l*32 +: 32] <=
              fill_word({first_tag + tag_t'(w), 8'(s), 2'(l), 2'b00});
          end
        end
      end
    end else begin
      rd_valid_q <= (sram_req_o != '0) && !sram_we_o;
      if ((sram_req_o != '0) && !sram_we_o) rd_set_q <= sram_addr_o[11:4];
      if ((sram_req_o != '0) && sram_we_o && sram_gnt_i) begin
        for (int w = 0; w < ways; w++) begin
          for (int b = 0; b < 16; b++) begin
            if (sram_req_o[w] && sram_be_o[b]) begin
              line_mem[w][sram_addr_o[11:4]][b*8 +: 8] <= sram_data_o[b*8 +: 8];
              dirty_mem[w][sram_addr_o[11:4]][b/4]    <= 1'b1;
            end
          end
          if (sram_req_o[w]) valid_mem[w][sram_addr_o[11:4]] <= 1'b1;
        end
      end
    end
  end

  // tag compare against the live tag
  always_comb begin
    hit_way_i = '0;
    for (int w = 0; w < ways; w++) begin
      sram_rdata_i[w] = line_mem[w][rd_set_q];
      hit_way_i[w] = rd_valid_q && valid_mem[w][rd_set_q] &&
                     (tag_mem[w][rd_set_q] == sram_tag_o);
    end
  end

  // random SRAM arbitration
  initial begin
    sram_gnt_i = 1'b0;
    forever begin
      @(negedge clk_i);
      sram_gnt_i = ($urandom_range(3, 0) != 0);
    end
  end

  //--------------------------------------------------------------------------
  // miss and bypass units with random delays
  //--------------------------------------------------------------------------
  initial begin : miss_unit
    logic we, byp;
    paddr_t addr;
    miss_gnt_i = 1'b0;
    bypass_gnt_i = 1'b0;
    critical_word_valid_i = 1'b0;
    bypass_valid_i = 1'b0;
    critical_word_i = '0;
    bypass_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (miss_valid_o) begin
        assert (miss_addr_o === exp_miss_addr && miss_bypass_o === exp_bypass &&
                miss_we_o === exp_we)
        else report_mismatch($sformatf("miss request addr %h bypass %b we %b, expected %h %b %b",
          miss_addr_o, miss_bypass_o, miss_we_o, exp_miss_addr, exp_bypass, exp_we));
        if (exp_we) begin
          assert (miss_be_o === exp_be && miss_wdata_o === exp_wdata)
          else report_mismatch($sformatf("miss store be %h data %h, expected %h %h",
            miss_be_o, miss_wdata_o, exp_be, exp_wdata));
        end
        we = miss_we_o;
        byp = miss_bypass_o;
        addr = miss_addr_o;
        repeat ($urandom_range(3, 0)) @(negedge clk_i);
        if (byp) bypass_gnt_i = 1'b1;
        else miss_gnt_i = 1'b1;
        @(negedge clk_i);
        miss_gnt_i = 1'b0;
        bypass_gnt_i = 1'b0;
        if (!we) begin
          repeat ($urandom_range(4, 0)) @(negedge clk_i);
          if (byp) begin
            bypass_valid_i = 1'b1;
            bypass_data_i = backing_word(addr);
          end else begin
            critical_word_valid_i = 1'b1;
            critical_word_i = backing_word(addr);
          end
          @(negedge clk_i);
          bypass_valid_i = 1'b0;
          critical_word_valid_i = 1'b0;
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // one core access, from request to grant or read data
  //--------------------------------------------------------------------------
  task automatic run_access(input logic we, input be_t be, input word_t wdata,
                            input paddr_t addr, input logic byp, input int stall_cycles);
    tag_t tag;
    logic hit, accepted, done, first, strobe_ok;
    int n;
    word_t rdata, exp;
    tag = addr[31:12];
    hit = !byp && (tag >= first_tag) && (tag <= first_tag + 20'd3);
    exp_miss_addr = addr;
    exp_bypass = byp || (tag >= cacheable_tag_limit);
    exp_we = we;
    exp_be = be;
    exp_wdata = wdata;
    strobe_ok = 1'b0;
    @(negedge clk_i);
    data_req_i = 1'b1;
    data_we_i = we;
    data_be_i = be;
    data_wdata_i = wdata;
    address_index_i = addr[11:0];
    address_tag_i = tag;
    bypass_i = byp;
    stall_i = (stall_cycles > 0);
    accepted = 1'b0;
    n = 0;
    while (!accepted) begin
      @(posedge clk_i);
      if (!stall_i && (bypass_i || sram_gnt_i)) begin
        accepted = 1'b1;
        assert (data_gnt_o === !we) else report_mismatch("grant wrong on acceptance");
      end else begin
        assert (data_gnt_o === 1'b0 && busy_o === 1'b0)
        else report_mismatch("grant or busy while request held back");
      end
      @(negedge clk_i);
      n++;
      if (n >= stall_cycles) stall_i = 1'b0;
    end
    data_req_i = 1'b0;
    bypass_i = 1'b0;
    assert (busy_o === 1'b1) else report_mismatch("busy low after acceptance");
    if (!we) begin
      repeat ($urandom_range(3, 0)) @(negedge clk_i);
      tag_valid_i = 1'b1;
    end
    done = 1'b0;
    first = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      if (we ? data_gnt_o : data_rvalid_o) begin
        done = 1'b1;
        rdata = data_rdata_o;
        // completion has to line up with the write, grant or answer behind it
        if (hit) begin
          strobe_ok = !we || (sram_gnt_i && sram_we_o);
        end else if (exp_bypass) begin
          strobe_ok = we ? bypass_gnt_i : bypass_valid_i;
        end else begin
          strobe_ok = we ? miss_gnt_i : critical_word_valid_i;
        end
      end else begin
        assert (!(hit && !we && first))
        else report_mismatch("load hit not returned in the tag-valid cycle");
        assert (busy_o === 1'b1) else report_mismatch("busy low before completion");
      end
      first = 1'b0;
      @(negedge clk_i);
    end
    tag_valid_i = 1'b0;
    assert (busy_o === 1'b0) else report_mismatch("busy still high after completion");
    assert (strobe_ok === 1'b1)
    else report_mismatch("request completed without its grant or response");
    if (!we) begin
      exp = hit ? cached_word(addr) : backing_word(addr);
      assert (rdata === exp)
      else report_mismatch($sformatf("load %h returned %h, expected %h", addr, rdata, exp));
    end else if (hit) begin
      shadow[addr] = merge_word(cached_word(addr), wdata, be);
      assert (dirty_mem[tag - first_tag][addr[11:4]][addr[3:2]] === 1'b1)
      else report_mismatch($sformatf("store hit %h left its word lane clean", addr));
    end
  endtask

  //--------------------------------------------------------------------------
  // watchdog
  //--------------------------------------------------------------------------
  initial begin
    repeat (num_requests * 200 + 10) @(posedge clk_i);
    $display("watchdog expired, a request never completed");
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin : stimulus
    paddr_t addr;
    tag_t tag;
    void'($urandom(41510));
    rst_ni = 1'b0;
    bypass_i = 1'b0;
    stall_i = 1'b0;
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    data_be_i = '0;
    data_wdata_i = '0;
    address_index_i = '0;
    address_tag_i = '0;
    tag_valid_i = 1'b0;
    exp_miss_addr = '0;
    exp_bypass = 1'b0;
    exp_we = 1'b0;
    exp_be = '0;
    exp_wdata = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // hit, store hit and read back
    run_access(1'b0, 4'hf, '0, {20'h00101, 12'h358}, 1'b0, 0);
    run_access(1'b1, 4'b0101, 32'hDEAD_BEEF, {20'h00101, 12'h358}, 1'b0, 0);
    run_access(1'b0, 4'hf, '0, {20'h00101, 12'h358}, 1'b0, 0);
    // load miss and store miss
    run_access(1'b0, 4'hf, '0, {20'h00456, 12'h340}, 1'b0, 0);
    run_access(1'b1, 4'b1100, 32'h1234_5678, {20'h00456, 12'h344}, 1'b0, 0);
    // uncacheable tag and forced bypass
    run_access(1'b0, 4'hf, '0, {20'h9ABCD, 12'h120}, 1'b0, 0);
    run_access(1'b1, 4'b0011, 32'hCAFE_F00D, {20'h00102, 12'h0F0}, 1'b1, 0);
    run_access(1'b0, 4'hf, '0, {20'h00103, 12'h0F4}, 1'b1, 0);
    // held back by stall
    run_access(1'b0, 4'hf, '0, {20'h00100, 12'h008}, 1'b0, 4);

    // random mix
    for (int i = 0; i < num_requests - 9; i++) begin
      case ($urandom_range(2, 0))
        0: tag = first_tag + tag_t'($urandom_range(3, 0));
        1: tag = 20'h00456 + tag_t'($urandom_range(15, 0));
        default: tag = cacheable_tag_limit + tag_t'($urandom_range(255, 0));
      endcase
      addr = {tag, 8'($urandom_range(255, 0)), 2'($urandom_range(3, 0)), 2'b00};
      run_access(1'($urandom_range(1, 0)), 4'($urandom_range(15, 1)), $urandom(),
                 addr, ($urandom_range(3, 0) == 0), $urandom_range(2, 0));
    end

    repeat (2) @(negedge clk_i);
    $display("Test OK");
    $finish;
  end

endmodule

//--- sources.f
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/ctrl_dp_if.sv
rtl/cache_ctrl_fsm.sv
rtl/req_buffer.sv
rtl/line_datapath.sv
rtl/cache_ctrl_top.sv
sim/cache_ctrl_properties.sv
sim/tb_cache_ctrl.sv
